/* files.f */
+incdir+verilog
verilog/dpmem_pkg.sv
verilog/dpmem_ram.sv
verilog/dpmem_wr_stage.sv
verilog/dpmem_rd_stage.sv
verilog/dpmem_top.sv
testbench/dpmem_asserts.sv
testbench/dpmem_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dpmem_tb -f files.f -o dpmem_sim \
   && ./obj_dir/dpmem_sim || exit 1

/* testbench/dpmem_asserts.sv */
// bound into dpmem_top; checks response hold, bist write block and post reset state only
`include "dpmem_defs.svh"
`default_nettype none

module dpmem_asserts (
   input wire                   clk,
   input wire                   reset,
   input wire                   bist_en,
   input wire                   wr_ready,
   input wire                   rsp_valid,
   input wire                   rsp_ready,
   input wire [`DPMEM_DW-1:0]   rsp_data     // response word as a flat vector
);

   // ############################
   // response channel
   // ############################

   rsp_hold: assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))   // stalled word stays put
      else $error("response changed while stalled");

   rsp_after_reset: assert property (@(posedge clk) reset |=> !rsp_valid)
      else $error("rsp_valid high in the cycle after reset");

   // ############################
   // write channel
   // ############################

   bist_blocks_wr: assert property (@(posedge clk) bist_en |-> !wr_ready)   // bist owns the port
      else $error("wr_ready high while bist_en is high");

endmodule

bind dpmem_top dpmem_asserts u_asserts (
   .clk       (clk),
   .reset     (reset),
   .bist_en   (bist_en),
   .wr_ready  (wr_ready),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp_data  (rsp)
);

`default_nettype wire

/* testbench/dpmem_tb.sv */
// assumes 32 bit words for the random generator; memory is unknown until the first phase fills it
`include "dpmem_defs.svh"
`default_nettype none

module dpmem_tb;

   logic                 clk;
   logic                 reset;
   logic                 wr_valid;
   dpmem_pkg::wr_req_t   wr_req;
   logic                 wr_ready;
   logic                 bist_en;
   dpmem_pkg::bist_t     bist;
   logic                 rd_valid;
   dpmem_pkg::rd_req_t   rd_req;
   logic                 rd_ready;
   logic                 rsp_valid;
   dpmem_pkg::rd_rsp_t   rsp;
   logic                 rsp_ready;

   logic [`DPMEM_DW-1:0] mirror [`DPMEM_DEPTH];   // expected contents
   logic [`DPMEM_DW-1:0] exp_q [$];               // expected responses, oldest first
   dpmem_pkg::mem_wr_t   pend;                    // held in the DUT, stored next edge
   logic [31:0]          stim_seed;
   logic [31:0]          rsp_seed;
   logic [4:0]           busy_level;              // 0 keeps rsp_ready high, 16 holds it low
   int                   n_acc;                   // reads accepted
   int                   n_rsp;                   // responses taken

   dpmem_top dut (
      .clk       (clk),
      .reset     (reset),
      .wr_valid  (wr_valid),
      .wr_req    (wr_req),
      .wr_ready  (wr_ready),
      .bist_en   (bist_en),
      .bist      (bist),
      .rd_valid  (rd_valid),
      .rd_req    (rd_req),
      .rd_ready  (rd_ready),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .rsp_ready (rsp_ready)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;                         // period 40

   // ############################
   // helpers
   // ############################

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] rand_next();
      stim_seed = lcg_step(stim_seed);
      return stim_seed;
   endfunction

   function automatic dpmem_pkg::wr_req_t rand_req();
      dpmem_pkg::wr_req_t w;
      logic [31:0]        r;
      r      = rand_next();
      w.addr = r[`DPMEM_AW+15:16];                // upper bits, low ones cycle short
      w.data = rand_next();
      w.mask = rand_next();
      return w;
   endfunction

   // old word with the masked bits taken from the new word
   function automatic logic [`DPMEM_DW-1:0] merge_word(input logic [`DPMEM_DW-1:0] old_word,
      input logic [`DPMEM_DW-1:0] new_word, input logic [`DPMEM_DW-1:0] mask);
      logic [`DPMEM_DW-1:0] res;
      for (int b = 0; b < `DPMEM_DW; b++) begin
         res[b] = mask[b] ? new_word[b] : old_word[b];
      end
      return res;
   endfunction

   task automatic stop_failed();
      $display("Something failed");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic value_error(input string msg);
      $display("** Error at time %0t: %s", $time, msg);
      stop_failed();
   endtask

   task automatic protocol_error(input string msg);
      $display("Check failed at time %0t: %s", $time, msg);
      stop_failed();
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) @(negedge clk);                  // five rising edges in reset
      reset = 1'b0;
   endtask

   // starts and ends on a falling edge; drops each valid once it is taken
   task automatic issue(input logic do_wr, input dpmem_pkg::wr_req_t w, input logic do_rd,
      input logic [`DPMEM_AW-1:0] ra);
      int   t;
      logic wr_done;
      logic rd_done;
      wr_done     = !do_wr;
      rd_done     = !do_rd;
      wr_valid    = do_wr;
      wr_req      = w;
      rd_valid    = do_rd;
      rd_req.addr = ra;
      t           = 0;
      while (!(wr_done && rd_done)) begin
         @(posedge clk);
         if (wr_valid && wr_ready) wr_done = 1'b1;
         if (rd_valid && rd_ready) rd_done = 1'b1;
         @(negedge clk);
         if (wr_done) wr_valid = 1'b0;
         if (rd_done) rd_valid = 1'b0;
         t++;
         assert (t < 60) else protocol_error("timed out waiting for a request handshake");
      end
   endtask

   task automatic drain();
      int t;
      t = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         t++;
         assert (t < 300) else protocol_error("timed out waiting for responses to drain");
      end
   endtask

   task automatic read_all();
      dpmem_pkg::wr_req_t w;
      w = '0;
      for (int a = 0; a < `DPMEM_DEPTH; a++) begin
         issue(1'b0, w, 1'b1, a[`DPMEM_AW-1:0]);
      end
      drain();
   endtask

   // bist writes while one request waits with valid high
   task automatic bist_burst(input int n);
      logic [31:0] r;
      int          t;
      wr_req   = rand_req();
      wr_valid = 1'b1;
      bist_en  = 1'b1;
      for (int k = 0; k < n; k++) begin
         r         = rand_next();
         bist.we   = r[27] | r[26];               // mostly enabled
         bist.addr = r[`DPMEM_AW+15:16];
         bist.wem  = rand_next();
         bist.din  = rand_next();
         @(posedge clk);
         assert (!(wr_valid && wr_ready)) else protocol_error("write accepted during BIST");
         @(negedge clk);
      end
      bist_en = 1'b0;
      bist.we = 1'b0;
      t       = 0;
      while (wr_valid) begin
         @(posedge clk);
         t++;
         assert (t < 20) else protocol_error("timed out waiting for the held write");
         if (wr_ready) begin
            @(negedge clk);
            wr_valid = 1'b0;
         end
      end
   endtask

   // ############################
   // mirror and comparison
   // ############################

   always @(posedge clk) begin
      if (!reset && rd_valid && rd_ready) begin
         exp_q.push_back(mirror[rd_req.addr]);    // same edge store not yet visible
         n_acc++;
      end
      if (pend.en) begin
         mirror[pend.addr] = merge_word(mirror[pend.addr], pend.data, pend.mask);
      end
      pend.en   = !reset && (bist_en ? bist.we : (wr_valid && wr_ready));
      pend.addr = bist_en ? bist.addr : wr_req.addr;
      pend.mask = bist_en ? bist.wem : wr_req.mask;
      pend.data = bist_en ? bist.din : wr_req.data;
   end

   always @(posedge clk) begin
      logic [`DPMEM_DW-1:0] expected;
      if (!reset && rsp_valid && rsp_ready) begin
         assert (exp_q.size() != 0) else protocol_error("response with no read outstanding");
         expected = exp_q.pop_front();
         n_rsp++;
         assert (rsp.data === expected)
            else value_error($sformatf("read data %h, expected %h", rsp.data, expected));
      end
   end

   always @(negedge clk) begin
      rsp_seed  = lcg_step(rsp_seed);
      rsp_ready = ({1'b0, rsp_seed[27:24]} >= busy_level);   // own stream for back-pressure
      if (!reset) begin
         assert (n_acc - n_rsp <= 2) else protocol_error("more than two reads outstanding");
      end
   end

   // ############################
   // stimulus
   // ############################

   initial begin
      dpmem_pkg::wr_req_t   w;
      logic [31:0]          r;
      logic [`DPMEM_AW-1:0] last_wa;
      wr_valid   = 1'b0;
      wr_req     = '0;
      bist_en    = 1'b0;
      bist       = '0;
      rd_valid   = 1'b0;
      rd_req     = '0;
      rsp_ready  = 1'b1;
      stim_seed  = 32'd38;
      rsp_seed   = lcg_step(32'd38);
      busy_level = 5'd0;
      pend       = '0;
      n_acc      = 0;
      n_rsp      = 0;
      last_wa    = '0;
      apply_reset();
      for (int a = 0; a < `DPMEM_DEPTH; a++) begin   // fill every word
         w      = rand_req();
         w.addr = a[`DPMEM_AW-1:0];
         w.mask = '1;
         issue(1'b1, w, 1'b0, '0);
      end
      read_all();
      for (int k = 0; k < 40; k++) begin
         issue(1'b1, rand_req(), 1'b0, '0);       // masked writes
      end
      read_all();
      for (int k = 0; k < 160; k++) begin
         if (k == 80) busy_level = 5'd12;         // rsp_ready mostly low from here
         w = rand_req();
         r = rand_next();
         issue(r[28], w, r[29] | ~r[28], r[27] ? last_wa : r[`DPMEM_AW+15:16]);
         if (r[28]) last_wa = w.addr;             // next read may collide
      end
      drain();
      busy_level = 5'd0;
      bist_burst(12);
      read_all();
      busy_level = 5'd16;                         // responses stall in the buffer
      issue(1'b0, w, 1'b1, last_wa);
      issue(1'b0, w, 1'b1, w.addr);
      apply_reset();                              // reads still pending here
      exp_q.delete();                             // reset drops pending responses
      n_acc      = 0;
      n_rsp      = 0;
      busy_level = 5'd0;
      for (int k = 0; k < 4; k++) begin
         @(negedge clk);
         assert (rsp_valid === 1'b0) else value_error("rsp_valid high after reset, no read");
      end
      issue(1'b0, w, 1'b1, last_wa);
      drain();
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/dpmem_defs.svh */
// memory geometry; depth must be a power of two and all macros are global to the compile
`ifndef DPMEM_DEFS_SVH
`define DPMEM_DEFS_SVH

// ############################
// memory geometry
// ############################

// bits per memory word
`define DPMEM_DW 32

// number of words, power of two
`define DPMEM_DEPTH 32

// address width follows from the depth
`define DPMEM_AW $clog2(`DPMEM_DEPTH)

// ############################
// derived helpers
// ############################

`define DPMEM_DATA_T logic [`DPMEM_DW-1:0]   // one memory word
`define DPMEM_ADDR_T logic [`DPMEM_AW-1:0]   // one word address

`endif

/* verilog/dpmem_pkg.sv */
// shared channel and port structs; widths come from dpmem_defs.svh and are fixed per compile
`include "dpmem_defs.svh"
`default_nettype none

package dpmem_pkg;

   // ############################
   // request and response channels
   // ############################

   typedef struct packed {
      `DPMEM_ADDR_T addr;                     // target word
      `DPMEM_DATA_T data;                     // write data
      `DPMEM_DATA_T mask;                     // per bit write enable
   } wr_req_t;

   typedef struct packed {
      `DPMEM_ADDR_T addr;                     // word to read
   } rd_req_t;

   typedef struct packed {
      `DPMEM_DATA_T data;                     // returned word
   } rd_rsp_t;

   // ############################
   // memory side ports
   // ############################

   typedef struct packed {
      logic         en;                       // write strobe
      `DPMEM_ADDR_T addr;
      `DPMEM_DATA_T mask;                     // bit enables, 1 = write
      `DPMEM_DATA_T data;
   } mem_wr_t;

   typedef struct packed {
      logic         we;                       // global write enable
      `DPMEM_DATA_T wem;                      // write enable vector
      `DPMEM_ADDR_T addr;
      `DPMEM_DATA_T din;
   } bist_t;

endpackage

`default_nettype wire

/* verilog/dpmem_ram.sv */
// behavioral model only; no power, config or repair pins, contents undefined after power up
`include "dpmem_defs.svh"
`default_nettype none

module dpmem_ram (
   // ############################
   // write port
   // ############################
   input  wire                    wr_clk,    // write clock
   input  dpmem_pkg::mem_wr_t     mem_wr,    // enable, address, bit mask, data
   // ############################
   // read port
   // ############################
   input  wire                    rd_clk,    // read clock
   input  wire                    rd_en,     // read strobe
   input  wire  [`DPMEM_AW-1:0]   rd_addr,   // read address
   output logic [`DPMEM_DW-1:0]   rd_data    // registered read word
);

   logic [`DPMEM_DW-1:0] mem [`DPMEM_DEPTH];  // storage array, no reset

   // write side
   // only masked bits change, the rest keep old contents
   always_ff @(posedge wr_clk) begin
      if (mem_wr.en) begin
         mem[mem_wr.addr] <= (mem[mem_wr.addr] & ~mem_wr.mask) |
                             (mem_wr.data & mem_wr.mask);   // bitwise merge
      end
   end

   // read side
   // same edge write is not visible, read gets old word
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];             // hold when idle
      end
   end

endmodule

`default_nettype wire

/* verilog/dpmem_rd_stage.sv */
// at most two reads in flight or buffered; responses return strictly in request order
`include "dpmem_defs.svh"
`default_nettype none

module dpmem_rd_stage (
   input  wire                    clk,
   input  wire                    reset,        // sync, active high
   // ############################
   // read request channel
   // ############################
   input  wire                    rd_valid,
   input  dpmem_pkg::rd_req_t     rd_req,
   output logic                   rd_ready,
   // ############################
   // ram read port
   // ############################
   output logic                   ram_rd_en,
   output logic [`DPMEM_AW-1:0]   ram_rd_addr,
   input  wire  [`DPMEM_DW-1:0]   ram_rd_data,  // valid one cycle after ram_rd_en
   // ############################
   // response channel
   // ############################
   output logic                   rsp_valid,
   output dpmem_pkg::rd_rsp_t     rsp,
   input  wire                    rsp_ready
);

   logic               in_flight;               // ram read issued last edge
   logic [1:0]         buf_cnt;                 // buffered responses, 0..2
   logic               wr_ptr;                  // next free slot
   logic               rd_ptr;                  // oldest slot
   dpmem_pkg::rd_rsp_t rsp_buf [2];             // ordered two entry buffer
   logic [1:0]         occupancy;               // in flight plus buffered
   logic               push;
   logic               pop;

   // ############################
   // handshake
   // ############################

   assign push      = in_flight;                // ram word arrives now
   assign pop       = rsp_valid & rsp_ready;    // response leaves now
   assign occupancy = {1'b0, in_flight} + buf_cnt;
   // a leaving response frees a slot the same cycle
   assign rd_ready  = (occupancy != 2'd2) | pop;

   assign ram_rd_en   = rd_valid & rd_ready;    // read issued on acceptance
   assign ram_rd_addr = rd_req.addr;

   assign rsp_valid = (buf_cnt != 2'd0);
   assign rsp       = rsp_buf[rd_ptr];          // head stays put until pop

   // ############################
   // control state
   // ############################

   always_ff @(posedge clk) begin
      if (reset) begin
         in_flight <= 1'b0;
         buf_cnt   <= 2'd0;
         wr_ptr    <= 1'b0;
         rd_ptr    <= 1'b0;
      end else begin
         in_flight <= ram_rd_en;
         if (push) begin
            wr_ptr <= ~wr_ptr;                  // wrap over two slots
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, pop})
            2'b10:   buf_cnt <= buf_cnt + 2'd1;
            2'b01:   buf_cnt <= buf_cnt - 2'd1;
            default: buf_cnt <= buf_cnt;        // both or neither
         endcase
      end
   end

   // buffer data, no reset
   // the push slot is never the head while the head is valid
   always_ff @(posedge clk) begin
      if (push) begin
         rsp_buf[wr_ptr].data <= ram_rd_data;
      end
   end

endmodule

`default_nettype wire

/* verilog/dpmem_top.sv */
// single clock build; ram write and read clocks are both tied to clk, no clock crossing
`include "dpmem_defs.svh"
`default_nettype none

module dpmem_top (
   input  wire                  clk,
   input  wire                  reset,       // sync, active high
   // ############################
   // write channel and bist
   // ############################
   input  wire                  wr_valid,
   input  dpmem_pkg::wr_req_t   wr_req,
   output logic                 wr_ready,
   input  wire                  bist_en,
   input  dpmem_pkg::bist_t     bist,
   // ############################
   // read and response channels
   // ############################
   input  wire                  rd_valid,
   input  dpmem_pkg::rd_req_t   rd_req,
   output logic                 rd_ready,
   output logic                 rsp_valid,
   output dpmem_pkg::rd_rsp_t   rsp,
   input  wire                  rsp_ready
);

   dpmem_pkg::mem_wr_t         mem_wr;      // write stage to ram
   logic                       ram_rd_en;
   logic [`DPMEM_AW-1:0]       ram_rd_addr;
   logic [`DPMEM_DW-1:0]       ram_rd_data; // ram to read stage

   dpmem_wr_stage u_wr_stage (
      .clk      (clk),
      .reset    (reset),
      .wr_valid (wr_valid),
      .wr_req   (wr_req),
      .wr_ready (wr_ready),
      .bist_en  (bist_en),
      .bist     (bist),
      .mem_wr   (mem_wr)
   );

   dpmem_ram u_ram (
      .wr_clk   (clk),                     // same clock both ports
      .mem_wr   (mem_wr),
      .rd_clk   (clk),
      .rd_en    (ram_rd_en),
      .rd_addr  (ram_rd_addr),
      .rd_data  (ram_rd_data)
   );

   dpmem_rd_stage u_rd_stage (
      .clk         (clk),
      .reset       (reset),
      .rd_valid    (rd_valid),
      .rd_req      (rd_req),
      .rd_ready    (rd_ready),
      .ram_rd_en   (ram_rd_en),
      .ram_rd_addr (ram_rd_addr),
      .ram_rd_data (ram_rd_data),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp),
      .rsp_ready   (rsp_ready)
   );

endmodule

`default_nettype wire

/* verilog/dpmem_wr_stage.sv */
// bist_en takes the write port outright; pending requests stall until it drops
`default_nettype none

module dpmem_wr_stage (
   input  wire                   clk,
   input  wire                   reset,      // sync, active high
   // ############################
   // write request channel
   // ############################
   input  wire                   wr_valid,
   input  dpmem_pkg::wr_req_t    wr_req,     // addr, data, mask
   output logic                  wr_ready,
   // ############################
   // bist override
   // ############################
   input  wire                   bist_en,    // bist owns the port
   input  dpmem_pkg::bist_t      bist,
   // ############################
   // ram write port
   // ############################
   output dpmem_pkg::mem_wr_t    mem_wr      // registered, one cycle ahead of store
);

   logic wr_accept;                          // request transfer this edge

   // no back-pressure from the memory, only bist blocks
   assign wr_ready  = ~bist_en;
   assign wr_accept = wr_valid & wr_ready;

   // write enable, cleared by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wr.en <= 1'b0;
      end else if (bist_en) begin
         mem_wr.en <= bist.we;               // global bist enable
      end else begin
         mem_wr.en <= wr_accept;             // one strobe per accepted request
      end
   end

   // payload, loaded from whichever source owns the port
   always_ff @(posedge clk) begin
      if (bist_en) begin
         mem_wr.addr <= bist.addr;
         mem_wr.mask <= bist.wem;            // bist bit enables
         mem_wr.data <= bist.din;
      end else if (wr_accept) begin
         mem_wr.addr <= wr_req.addr;
         mem_wr.mask <= wr_req.mask;         // request's own mask
         mem_wr.data <= wr_req.data;
      end
   end

endmodule

`default_nettype wire
